// ==== hw/mem_pkg.sv ====
package mem_pkg;

	// ##########################################################
	// scratchpad geometry.
	// ##########################################################

	localparam int mem_data_nbits  = 32;
	localparam int mem_num_entries = 64;
	localparam int mem_addr_nbits  = $clog2(mem_num_entries);
	localparam int mem_nbytes      = mem_data_nbits / 8;  // one enable per byte lane.

	typedef logic [mem_data_nbits-1:0] mem_word_t;

endpackage

// ==== hw/apb_map_pkg.sv ====
package apb_map_pkg;

	localparam int apb_addr_nbits = 12;
	localparam int apb_data_nbits = 32;

	// ##########################################################
	// address map, byte offsets on paddr.
	// ##########################################################

	localparam logic [apb_addr_nbits-1:0] mem_window_base = 12'h000;
	localparam logic [apb_addr_nbits-1:0] mem_window_size = 12'h100;  // 64 words.

	localparam logic [apb_addr_nbits-1:0] reg_ctrl      = 12'h100;  // bit 0 starts a clear.
	localparam logic [apb_addr_nbits-1:0] reg_status    = 12'h104;  // bit 0 is busy.
	localparam logic [apb_addr_nbits-1:0] reg_wr_count  = 12'h108;
	localparam logic [apb_addr_nbits-1:0] reg_rd_count  = 12'h10C;
	localparam logic [apb_addr_nbits-1:0] reg_err_count = 12'h110;

	// statistics counters.
	localparam int stat_nbits = 16;

endpackage

// ==== hw/sram_1rw_sync.sv ====
module sram_1rw_sync
	import mem_pkg::*;
(
	input  logic                      clk,
	input  logic                      read_en,
	input  logic [mem_addr_nbits-1:0] addr,
	output mem_word_t                 read_data,
	input  logic                      write_en,
	input  logic [mem_nbytes-1:0]     byte_en,
	input  mem_word_t                 write_data
);

	mem_word_t mem [mem_num_entries];

	// registered read, one cycle of latency.
	always_ff @(posedge clk) begin
		if (read_en)
			read_data <= mem[addr];
	end

	// each lane is written only when its enable is set.
	always_ff @(posedge clk) begin
		if (write_en) begin
			for (int i = 0; i < mem_nbytes; i++) begin
				if (byte_en[i])
					mem[addr][i*8 +: 8] <= write_data[i*8 +: 8];
			end
		end
	end

endmodule

// ==== hw/mem_clear_engine.sv ====
module mem_clear_engine
	import mem_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	output logic                      busy,
	output logic                      req,
	output logic [mem_addr_nbits-1:0] addr
);

	localparam logic [mem_addr_nbits-1:0] last_addr = mem_addr_nbits'(mem_num_entries - 1);

	// a zero word is written at every address while busy.
	assign req = busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			addr <= '0;
		end else if (busy) begin
			addr <= addr + 1'b1;
			if (addr == last_addr)
				busy <= 1'b0;  // last address written on this edge.
		end else if (start) begin
			busy <= 1'b1;
			addr <= '0;
		end
	end

endmodule

// ==== hw/mem_stats.sv ====
module mem_stats
	import apb_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ev_mem_write,
	input  logic                  ev_mem_read,
	input  logic                  ev_error,
	output logic [stat_nbits-1:0] wr_count,
	output logic [stat_nbits-1:0] rd_count,
	output logic [stat_nbits-1:0] err_count
);

	// holds at all ones instead of wrapping.
	function automatic logic [stat_nbits-1:0] sat_inc(input logic [stat_nbits-1:0] cnt);
		if (&cnt)
			return cnt;
		return cnt + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_count  <= '0;
			rd_count  <= '0;
			err_count <= '0;
		end else begin
			if (ev_mem_write)
				wr_count <= sat_inc(wr_count);
			if (ev_mem_read)
				rd_count <= sat_inc(rd_count);
			if (ev_error)
				err_count <= sat_inc(err_count);
		end
	end

endmodule

// ==== hw/apb_mem_front.sv ====
module apb_mem_front
	import mem_pkg::*;
	import apb_map_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	// apb slave.
	input  logic [apb_addr_nbits-1:0]   paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [apb_data_nbits-1:0]   pwdata,
	input  logic [apb_data_nbits/8-1:0] pstrb,
	output logic [apb_data_nbits-1:0]   prdata,
	output logic                        pready,
	output logic                        pslverr,
	// sram port.
	output logic                        sram_read_en,
	output logic                        sram_write_en,
	output logic [mem_addr_nbits-1:0]   sram_addr,
	output logic [mem_nbytes-1:0]       sram_byte_en,
	output mem_word_t                   sram_write_data,
	input  mem_word_t                   sram_read_data,
	// clear engine.
	input  logic                        clr_busy,
	input  logic                        clr_req,
	input  logic [mem_addr_nbits-1:0]   clr_addr,
	output logic                        clear_start,
	// statistics.
	output logic                        ev_mem_write,
	output logic                        ev_mem_read,
	output logic                        ev_error,
	input  logic [stat_nbits-1:0]       wr_count,
	input  logic [stat_nbits-1:0]       rd_count,
	input  logic [stat_nbits-1:0]       err_count
);

	typedef enum logic {
		rd_idle,
		rd_wait
	} rd_state_t;

	rd_state_t rd_state;
	rd_state_t rd_state_next;

	logic                      access;
	logic [apb_addr_nbits-1:0] mem_offset;
	logic                      in_mem;
	logic                      is_ctrl;
	logic                      is_status;
	logic                      is_wr_cnt;
	logic                      is_rd_cnt;
	logic                      is_err_cnt;
	logic                      ro_reg;
	logic                      dec_err;
	logic                      mem_rd_issue;

	// ##########################################################
	// address decode
	// ##########################################################

	assign access     = psel && penable;
	assign mem_offset = paddr - mem_window_base;
	assign in_mem     = mem_offset < mem_window_size;  // wrap also rejects paddr below base.

	assign is_ctrl    = paddr == reg_ctrl;
	assign is_status  = paddr == reg_status;
	assign is_wr_cnt  = paddr == reg_wr_count;
	assign is_rd_cnt  = paddr == reg_rd_count;
	assign is_err_cnt = paddr == reg_err_count;
	assign ro_reg     = is_status || is_wr_cnt || is_rd_cnt || is_err_cnt;

	// unmapped space, or a write to a read-only register.
	assign dec_err = !in_mem && !is_ctrl && !(ro_reg && !pwrite);

	// ##########################################################
	// read wait state
	// ##########################################################

	assign mem_rd_issue = access && in_mem && !pwrite && !clr_busy && (rd_state == rd_idle);

	always_comb begin
		rd_state_next = rd_state;
		case (rd_state)
			rd_idle: begin
				if (mem_rd_issue)
					rd_state_next = rd_wait;
			end
			rd_wait: rd_state_next = rd_idle;  // data is on read_data now.
			default: rd_state_next = rd_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_state <= rd_idle;
		else
			rd_state <= rd_state_next;
	end

	// ##########################################################
	// sram port, owned by the engine while a clear runs
	// ##########################################################

	always_comb begin
		if (clr_busy) begin
			sram_read_en    = 1'b0;
			sram_write_en   = clr_req;
			sram_addr       = clr_addr;
			sram_byte_en    = '1;
			sram_write_data = '0;
		end else begin
			sram_read_en    = mem_rd_issue;
			sram_write_en   = access && in_mem && pwrite;
			sram_addr       = mem_offset[mem_addr_nbits+1:2];
			sram_byte_en    = pstrb;
			sram_write_data = pwdata;
		end
	end

	// ##########################################################
	// response
	// ##########################################################

	always_comb begin
		pready = 1'b0;
		if (access) begin
			if (!in_mem)
				pready = 1'b1;  // registers and errors never wait.
			else if (pwrite)
				pready = !clr_busy;
			else
				pready = rd_state == rd_wait;
		end
	end

	assign pslverr = access && dec_err;

	always_comb begin
		prdata = '0;
		if (in_mem)
			prdata = sram_read_data;
		else if (is_status)
			prdata = apb_data_nbits'(clr_busy);
		else if (is_wr_cnt)
			prdata = apb_data_nbits'(wr_count);
		else if (is_rd_cnt)
			prdata = apb_data_nbits'(rd_count);
		else if (is_err_cnt)
			prdata = apb_data_nbits'(err_count);
	end

	// strobes are high in the cycle that ends with the completing edge.
	assign ev_mem_write = access && in_mem && pwrite && !clr_busy;
	assign ev_mem_read  = access && in_mem && !pwrite && (rd_state == rd_wait);
	assign ev_error     = access && dec_err;
	assign clear_start  = access && pwrite && is_ctrl && pwdata[0];

endmodule

// ==== hw/apb_mem_top.sv ====
module apb_mem_top
	import mem_pkg::*;
	import apb_map_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [apb_addr_nbits-1:0]   paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [apb_data_nbits-1:0]   pwdata,
	input  logic [apb_data_nbits/8-1:0] pstrb,
	output logic [apb_data_nbits-1:0]   prdata,
	output logic                        pready,
	output logic                        pslverr
);

	logic                      sram_read_en;
	logic                      sram_write_en;
	logic [mem_addr_nbits-1:0] sram_addr;
	logic [mem_nbytes-1:0]     sram_byte_en;
	mem_word_t                 sram_write_data;
	mem_word_t                 sram_read_data;

	logic                      clr_busy;
	logic                      clr_req;
	logic [mem_addr_nbits-1:0] clr_addr;
	logic                      clear_start;

	logic                      ev_mem_write;
	logic                      ev_mem_read;
	logic                      ev_error;
	logic [stat_nbits-1:0]     wr_count;
	logic [stat_nbits-1:0]     rd_count;
	logic [stat_nbits-1:0]     err_count;

	// ##########################################################
	// request side
	// ##########################################################

	apb_mem_front u_front (
		.clk             (clk),
		.rst_n           (rst_n),
		.paddr           (paddr),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.pwdata          (pwdata),
		.pstrb           (pstrb),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.sram_read_en    (sram_read_en),
		.sram_write_en   (sram_write_en),
		.sram_addr       (sram_addr),
		.sram_byte_en    (sram_byte_en),
		.sram_write_data (sram_write_data),
		.sram_read_data  (sram_read_data),
		.clr_busy        (clr_busy),
		.clr_req         (clr_req),
		.clr_addr        (clr_addr),
		.clear_start     (clear_start),
		.ev_mem_write    (ev_mem_write),
		.ev_mem_read     (ev_mem_read),
		.ev_error        (ev_error),
		.wr_count        (wr_count),
		.rd_count        (rd_count),
		.err_count       (err_count)
	);

	mem_clear_engine u_clear (
		.clk   (clk),
		.rst_n (rst_n),
		.start (clear_start),
		.busy  (clr_busy),
		.req   (clr_req),
		.addr  (clr_addr)
	);

	// ##########################################################
	// storage and statistics
	// ##########################################################

	sram_1rw_sync u_sram (
		.clk        (clk),
		.read_en    (sram_read_en),
		.addr       (sram_addr),
		.read_data  (sram_read_data),
		.write_en   (sram_write_en),
		.byte_en    (sram_byte_en),
		.write_data (sram_write_data)
	);

	mem_stats u_stats (
		.clk          (clk),
		.rst_n        (rst_n),
		.ev_mem_write (ev_mem_write),
		.ev_mem_read  (ev_mem_read),
		.ev_error     (ev_error),
		.wr_count     (wr_count),
		.rd_count     (rd_count),
		.err_count    (err_count)
	);

endmodule

// ==== test/tb_apb_mem.sv ====
module tb_apb_mem
	import mem_pkg::*;
	import apb_map_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period   = 100;
	localparam int drive_delay  = 10;
	localparam int max_tests    = 64;
	localparam int stall_cycles = 90;  // longer than a whole clear.

	logic                        clk;
	logic                        rst_n;
	logic [apb_addr_nbits-1:0]   paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [apb_data_nbits-1:0]   pwdata;
	logic [apb_data_nbits/8-1:0] pstrb;
	logic [apb_data_nbits-1:0]   prdata;
	logic                        pready;
	logic                        pslverr;

	string       t_name  [max_tests];
	string       t_op    [max_tests];
	logic [31:0] t_addr  [max_tests];
	logic [31:0] t_wdata [max_tests];
	logic [3:0]  t_strb  [max_tests];
	logic [31:0] t_rdata [max_tests];
	logic        t_err   [max_tests];

	logic [7:0] model [mem_num_entries*mem_nbytes];  // expected memory bytes.
	time        clr_done_at;  // edge on which the running clear drops busy.
	int         num_tests;
	int         pass_cnt;
	int         fail_cnt;
	integer     seed;
	bit         loaded;

	apb_mem_top u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial clk = 1'b0;
	always #(clk_period/2) clk = ~clk;

	// ##########################################################
	// stimulus file and memory model
	// ##########################################################

	task automatic load_stim();
		int          fd;
		int          rc;
		string       line;
		string       name;
		string       op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] strb;
		logic [31:0] rdata;
		logic [31:0] err;
		fd = $fopen("test/apb_mem_stim.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && num_tests < max_tests) begin
			line = "";
			rc = $fgets(line, fd);
			if (line.len() > 1 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, wdata, strb,
					rdata, err);
				if (rc == 7) begin
					t_name[num_tests]  = name;
					t_op[num_tests]    = op;
					t_addr[num_tests]  = addr;
					t_wdata[num_tests] = wdata;
					t_strb[num_tests]  = strb[3:0];
					t_rdata[num_tests] = rdata;
					t_err[num_tests]   = err[0];
					num_tests++;
				end
			end
		end
		$fclose(fd);
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		int base;
		base = int'(addr[7:2]) * mem_nbytes;
		return {model[base+3], model[base+2], model[base+1], model[base]};
	endfunction

	// ##########################################################
	// apb master
	// ##########################################################

	task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [31:0] rdata, output logic err,
			output logic stalled, output int waits, output time access_at);
		int   waited;
		logic done;
		paddr   = addr[apb_addr_nbits-1:0];
		pwrite  = wr;
		pwdata  = data;
		pstrb   = strb;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		access_at = $time;
		#drive_delay;
		penable = 1'b1;
		waited  = 0;
		waits   = 0;
		done    = 1'b0;
		stalled = 1'b0;
		while (!done && !stalled) begin
			#(clk_period - 2*drive_delay);  // just before the edge.
			if (pready) begin
				rdata = prdata;
				err   = pslverr;
				waits = waited;
				done  = 1'b1;
			end
			@(posedge clk);
			#drive_delay;
			waited++;
			if (!done && waited >= stall_cycles)
				stalled = 1'b1;
		end
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic run_test(input int i);
		logic        wr;
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] rdata;
		logic        err;
		logic        stalled;
		logic        ok;
		int          waits;
		int          exp_waits;
		time         access_at;
		wr   = t_op[i] == "wr" || t_op[i] == "wrr";
		data = t_wdata[i];
		if (t_op[i] == "wrr")
			data = $random(seed);
		apb_transfer(wr, t_addr[i], data, t_strb[i], rdata, err, stalled, waits, access_at);
		expected = (t_op[i] == "rdm") ? model_word(t_addr[i]) : t_rdata[i];
		// memory accesses wait out a running clear, reads take one more cycle.
		exp_waits = 0;
		if (t_addr[i] < 32'(mem_window_size)) begin
			if (clr_done_at > access_at)
				exp_waits = int'((clr_done_at - access_at) / clk_period);
			if (!wr)
				exp_waits++;
		end
		ok = 1'b1;
		if (stalled) begin
			$display("%s: transfer never completed, pready stayed low", t_name[i]);
			ok = 1'b0;
		end else begin
			if (err !== t_err[i]) begin
				$display("[ERROR] %s pslverr expected %0d actual %0d", t_name[i], t_err[i], err);
				ok = 1'b0;
			end
			if (!wr && !t_err[i] && rdata !== expected) begin
				$display("[ERROR] %s expected %h actual %h", t_name[i], expected, rdata);
				ok = 1'b0;
			end
			if (waits != exp_waits) begin
				$display("[ERROR] %s wait states expected %0d actual %0d", t_name[i],
					exp_waits, waits);
				ok = 1'b0;
			end
		end
		// the model follows the address map, not the response.
		if (wr && !t_err[i] && t_addr[i] < 32'(mem_window_size)) begin
			for (int b = 0; b < mem_nbytes; b++) begin
				if (t_strb[i][b])
					model[int'(t_addr[i][7:2])*mem_nbytes + b] = data[b*8 +: 8];
			end
		end
		if (wr && t_addr[i] == 32'(reg_ctrl) && data[0] && $time >= clr_done_at) begin
			clr_done_at = $time - drive_delay + mem_num_entries * clk_period;
			for (int k = 0; k < mem_num_entries*mem_nbytes; k++)
				model[k] = 8'h00;
		end
		if (ok)
			pass_cnt++;
		else
			fail_cnt++;
		$display("test %s: %s", t_name[i], ok ? "pass" : "fail");
	endtask

	// ##########################################################
	// main sequence and watchdog
	// ##########################################################

	initial begin
		rst_n       = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		pstrb       = '0;
		seed        = 32'h95d7;
		clr_done_at = 0;
		num_tests   = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		load_stim();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
		if (num_tests == 0) begin
			$display("no test lines could be read from the stimulus file");
			fail_cnt++;
		end
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (loaded);
		#((num_tests * 100 + 200) * clk_period);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== test/apb_mem_stim.txt ====
# name op addr wdata strb exp_rdata exp_pslverr, all numbers in hex
# op: wr write, rd read, wrr write random data, rdm read checked against the model
wr_full         wr  000 a5a5f00d f 00000000 0
rd_full         rd  000 00000000 0 a5a5f00d 0
wr_last         wr  0fc 12345678 f 00000000 0
rd_last         rd  0fc 00000000 0 12345678 0
wr_lane0        wr  000 000000ee 1 00000000 0
wr_lane2        wr  000 00cc0000 4 00000000 0
rd_merge_a      rd  000 00000000 0 a5ccf0ee 0
wr_lanes13      wr  000 11223344 a 00000000 0
rd_merge_b      rd  000 00000000 0 11cc33ee 0
rnd_wr_full     wrr 040 00000000 f 00000000 0
rnd_rd_full     rdm 040 00000000 0 00000000 0
rnd_wr_mid      wrr 040 00000000 6 00000000 0
rnd_rd_mid      rdm 040 00000000 0 00000000 0
err_rd_unmapped rd  200 00000000 0 00000000 1
err_wr_unmapped wr  300 deadbeef f 00000000 1
err_wr_ro       wr  108 0000ffff f 00000000 1
err_rd_gap      rd  114 00000000 0 00000000 1
rd_after_err    rd  000 00000000 0 11cc33ee 0
cnt_wr_a        rd  108 00000000 0 00000007 0
cnt_rd_a        rd  10c 00000000 0 00000007 0
cnt_err_a       rd  110 00000000 0 00000004 0
clr_start       wr  100 00000001 f 00000000 0
status_busy     rd  104 00000000 0 00000001 0
rd_during_clr   rd  0fc 00000000 0 00000000 0
status_idle     rd  104 00000000 0 00000000 0
rd_cleared_0    rd  000 00000000 0 00000000 0
rd_cleared_40   rdm 040 00000000 0 00000000 0
cnt_wr_b        rd  108 00000000 0 00000007 0
cnt_rd_b        rd  10c 00000000 0 0000000a 0
cnt_err_b       rd  110 00000000 0 00000004 0

// ==== flist.f ====
hw/mem_pkg.sv
hw/apb_map_pkg.sv
hw/sram_1rw_sync.sv
hw/mem_clear_engine.sv
hw/mem_stats.sv
hw/apb_mem_front.sv
hw/apb_mem_top.sv
test/tb_apb_mem.sv

// ==== Bender.yml ====
package:
  name: apb_mem

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/apb_map_pkg.sv
      - hw/sram_1rw_sync.sv
      - hw/mem_clear_engine.sv
      - hw/mem_stats.sv
      - hw/apb_mem_front.sv
      - hw/apb_mem_top.sv
  - target: test
    files:
      - test/tb_apb_mem.sv
